// ==== scsi_dma.f ====
hdl/scsi_bus_pkg.sv
hdl/dma_fifo_pkg.sv
hdl/scsi_bus_sequencer.sv
hdl/dma_fifo.sv
hdl/cpu_scsi_port.sv
hdl/scsi_dma_top.sv
tests/scsi_chip_model.sv
tests/scsi_dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := scsi_dma_tb
FILELIST  := scsi_dma.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/scsi_dma_tb.sv ====
// Testbench for scsi_dma_top with FIFO_DEPTH 8, stops at the first mismatch or timeout
module scsi_dma_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import scsi_bus_pkg::*;
    import dma_fifo_pkg::*;

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 200;

    typedef enum {OP_WRITE, OP_READ, OP_DMA_IN, OP_DMA_OUT, OP_READ_IN_DMA, OP_FULL_STALL} op_t;
    typedef struct {
        op_t           kind;
        scsi_reg_sel_t sel;
        scsi_byte_t    data;
        scsi_byte_t    expected;
    } step_t;

    logic       CLK = 1'b0;
    logic       nRESET;
    cpu_cycle_t cpu;
    logic       dreq_n;
    logic       dmadir;
    logic       host_push;
    logic       host_pop;
    logic       sink_en;
    logic       src_push;
    scsi_byte_t src_byte;
    scsi_byte_t scsi_rdata;
    fifo_word_t host_wdata;
    scsi_bus_t  scsi_bus;
    logic       dsack;
    scsi_byte_t cpu_rdata;
    fifo_word_t host_rdata;
    logic       fifo_empty;
    logic       fifo_full;

    step_t      steps [11];
    scsi_byte_t src_bytes [8];
    fifo_word_t pushed [DEPTH];
    logic [3:0] addr_mirror;            // Expected IC address register
    logic [7:0] writes_done;

    always #2 CLK = ~CLK;

    scsi_dma_top #(.FIFO_DEPTH(DEPTH)) dut_i (
        .CLK(CLK), .nRESET(nRESET), .cpu(cpu), .dreq_n(dreq_n), .dmadir(dmadir),
        .host_push(host_push), .host_pop(host_pop), .scsi_rdata(scsi_rdata),
        .host_wdata(host_wdata), .scsi_bus(scsi_bus), .dsack(dsack), .cpu_rdata(cpu_rdata),
        .host_rdata(host_rdata), .fifo_empty(fifo_empty), .fifo_full(fifo_full)
    );

    scsi_chip_model model_i (
        .CLK(CLK), .nRESET(nRESET), .bus(scsi_bus), .dmadir(dmadir), .sink_en(sink_en),
        .src_push(src_push), .src_byte(src_byte), .rdata(scsi_rdata), .dreq_n(dreq_n)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input scsi_byte_t exp, input scsi_byte_t act);
        if (act !== exp)
            stop_with_error($sformatf("FAILED %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input fifo_word_t exp, input fifo_word_t act);
        if (act !== exp)
            stop_with_error($sformatf("FAILED %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_error($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    endtask

    task automatic report_timeout(input string what);
        stop_with_error($sformatf("Timeout while waiting for %s, sequencer in %s",
                                  what, dut_i.seq_i.state.name()));
    endtask

    task automatic wait_dsack(input logic level, input string name);
        int n;
        n = 0;
        @(negedge CLK);
        while (dsack !== level) begin
            n++;
            if (n > TIMEOUT)
                report_timeout($sformatf("dsack %b in %s", level, name));
            @(negedge CLK);
        end
    endtask

    task automatic wait_source_empty(input string name);
        int n;
        n = 0;
        @(negedge CLK);
        while (model_i.src_head != model_i.src_tail) begin
            n++;
            if (n > TIMEOUT)
                report_timeout($sformatf("source queue to drain in %s", name));
            @(negedge CLK);
        end
    endtask

    task automatic wait_sink(input logic [5:0] goal, input string name);
        int n;
        n = 0;
        @(negedge CLK);
        while (model_i.sink_cnt != goal || fifo_empty !== 1'b1) begin
            n++;
            if (n > TIMEOUT)
                report_timeout($sformatf("sink bytes and empty FIFO in %s", name));
            @(negedge CLK);
        end
    endtask

    // Holds req until dsack, then releases it and waits for dsack to fall
    task automatic run_cpu_cycle(input logic rw, input scsi_reg_sel_t sel, input scsi_byte_t data,
                                 input string name, output scsi_byte_t rd);
        @(posedge CLK);
        cpu <= '{req: 1'b1, rw: rw, sel: sel, wdata: data};
        wait_dsack(1'b1, name);
        rd = cpu_rdata;
        @(posedge CLK);
        cpu.req <= 1'b0;
        @(negedge CLK);
        check_bit({name, " dsack held"}, 1'b1, dsack);     // Still up until req is seen low
        wait_dsack(1'b0, name);
    endtask

    task automatic load_source(input int count);
        for (int i = 0; i < count; i++) begin
            src_bytes[i] = scsi_byte_t'($urandom);
            @(posedge CLK);
            src_push <= 1'b1;
            src_byte <= src_bytes[i];
        end
        @(posedge CLK);
        src_push <= 1'b0;
    endtask

    task automatic push_word(input fifo_word_t w);
        @(posedge CLK);
        host_push  <= 1'b1;
        host_wdata <= w;
        @(posedge CLK);
        host_push  <= 1'b0;
    endtask

    task automatic pop_and_check(input fifo_word_t exp, input string name);
        @(negedge CLK);
        check_word(name, exp, host_rdata);
        @(posedge CLK);
        host_pop <= 1'b1;
        @(posedge CLK);
        host_pop <= 1'b0;
    endtask

    function automatic fifo_word_t source_word(input int first);
        return {src_bytes[first], src_bytes[first+1], src_bytes[first+2], src_bytes[first+3]};
    endfunction

    task automatic load_table();
        steps[0]  = '{OP_WRITE,       1'b0, 8'h03, 8'h00};
        steps[1]  = '{OP_WRITE,       1'b1, 8'hA5, 8'h00};
        steps[2]  = '{OP_WRITE,       1'b1, 8'h3C, 8'h00};   // Back to back with the one above
        steps[3]  = '{OP_WRITE,       1'b0, 8'h03, 8'h00};
        steps[4]  = '{OP_READ,        1'b1, 8'h00, 8'hA5};
        steps[5]  = '{OP_READ,        1'b1, 8'h00, 8'h3C};
        steps[6]  = '{OP_DMA_IN,      1'b0, 8'h00, 8'h00};
        steps[7]  = '{OP_DMA_OUT,     1'b0, 8'h00, 8'h00};
        steps[8]  = '{OP_WRITE,       1'b0, 8'h03, 8'h00};
        steps[9]  = '{OP_READ_IN_DMA, 1'b1, 8'h00, 8'hA5};
        steps[10] = '{OP_FULL_STALL,  1'b0, 8'h00, 8'h00};
    endtask

    initial begin
        string      name;
        scsi_byte_t rd;
        logic [5:0] start;
        logic [5:0] head_before;
        fifo_word_t w;

        void'($urandom(84398));
        nRESET     = 1'b0;
        cpu        = '0;
        dmadir     = 1'b0;
        host_push  = 1'b0;
        host_pop   = 1'b0;
        host_wdata = '0;
        sink_en    = 1'b0;
        src_push   = 1'b0;
        src_byte   = '0;
        addr_mirror = '0;
        writes_done = '0;
        load_table();
        repeat (10) @(posedge CLK);
        nRESET <= 1'b1;

        for (int i = 0; i < 11; i++) begin
            name = $sformatf("step %0d %s", i, steps[i].kind.name());
            case (steps[i].kind)
                OP_WRITE: begin
                    run_cpu_cycle(1'b0, steps[i].sel, steps[i].data, name, rd);
                    writes_done = writes_done + 8'd1;
                    check_byte({name, " write count"}, writes_done, model_i.wr_count);
                    if (steps[i].sel) begin
                        check_byte(name, steps[i].data, model_i.regs[addr_mirror]);
                        addr_mirror = addr_mirror + 4'd1;
                    end else begin
                        addr_mirror = steps[i].data[3:0];
                    end
                end
                OP_READ: begin
                    run_cpu_cycle(1'b1, steps[i].sel, 8'h00, name, rd);
                    check_byte(name, steps[i].expected, rd);
                    addr_mirror = addr_mirror + 4'd1;
                end
                OP_DMA_IN, OP_READ_IN_DMA: begin
                    load_source(8);
                    @(posedge CLK);
                    dmadir <= 1'b1;
                    if (steps[i].kind == OP_READ_IN_DMA) begin
                        run_cpu_cycle(1'b1, steps[i].sel, 8'h00, name, rd);
                        check_byte(name, steps[i].expected, rd);
                        addr_mirror = addr_mirror + 4'd1;
                    end
                    wait_source_empty(name);
                    pop_and_check(source_word(0), {name, " word 0"});
                    pop_and_check(source_word(4), {name, " word 1"});
                    @(negedge CLK);
                    check_bit({name, " empty"}, 1'b1, fifo_empty);
                    @(posedge CLK);
                    dmadir <= 1'b0;
                end
                OP_DMA_OUT: begin
                    pushed[0] = fifo_word_t'($urandom);
                    pushed[1] = fifo_word_t'($urandom);
                    push_word(pushed[0]);
                    push_word(pushed[1]);
                    start = model_i.sink_cnt;
                    @(posedge CLK);
                    sink_en <= 1'b1;
                    wait_sink(start + 6'd8, name);
                    @(posedge CLK);
                    sink_en <= 1'b0;
                    for (int k = 0; k < 8; k++) begin
                        w = pushed[k / 4];
                        check_byte($sformatf("%s byte %0d", name, k),
                                   w[8*(3 - k % 4) +: 8], model_i.sink_mem[start + 6'(k)]);
                    end
                end
                OP_FULL_STALL: begin
                    for (int k = 0; k < DEPTH; k++) begin
                        pushed[k] = fifo_word_t'($urandom);
                        push_word(pushed[k]);
                    end
                    @(negedge CLK);
                    check_bit({name, " full"}, 1'b1, fifo_full);
                    load_source(4);
                    head_before = model_i.src_head;
                    @(posedge CLK);
                    dmadir <= 1'b1;
                    repeat (20) @(posedge CLK);             // Window where nothing may move
                    @(negedge CLK);
                    check_byte({name, " source held"}, 8'(head_before), 8'(model_i.src_head));
                    pop_and_check(pushed[0], {name, " word 0"});
                    wait_source_empty(name);
                    for (int k = 1; k < DEPTH; k++)
                        pop_and_check(pushed[k], $sformatf("%s word %0d", name, k));
                    pop_and_check(source_word(0), {name, " resumed word"});
                    @(negedge CLK);
                    check_bit({name, " empty"}, 1'b1, fifo_empty);
                    @(posedge CLK);
                    dmadir <= 1'b0;
                end
                default: stop_with_error($sformatf("Unknown table entry at %s", name));
            endcase
        end

        repeat (4) @(posedge CLK);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== tests/scsi_chip_model.sv ====
// Behavioral SCSI IC with 16 data registers, a 64-byte DMA source and a 64-byte DMA sink
module scsi_chip_model (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  scsi_bus_pkg::scsi_bus_t  bus,
    input  logic                     dmadir,
    input  logic                     sink_en,
    input  logic                     src_push,
    input  scsi_bus_pkg::scsi_byte_t src_byte,
    output scsi_bus_pkg::scsi_byte_t rdata,
    output logic                     dreq_n
);
    timeunit 1ns;
    timeprecision 100ps;
    import scsi_bus_pkg::*;

    scsi_byte_t regs [16];
    scsi_byte_t src_mem [64];
    scsi_byte_t sink_mem [64];
    logic [3:0] addr;
    logic [5:0] src_head;
    logic [5:0] src_tail;
    logic [5:0] sink_cnt;
    logic [7:0] wr_count;              // CPU register writes seen
    logic       prev_rd;
    logic       prev_wr;
    logic       prev_dma_rd;
    logic       prev_dma_wr;
    logic       cpu_rd;
    logic       cpu_wr;
    logic       dma_rd;
    logic       dma_wr;

    assign cpu_rd = bus.cs & bus.re;
    assign cpu_wr = bus.cs & bus.we;
    assign dma_rd = bus.dack & bus.re;
    assign dma_wr = bus.dack & bus.we;

    // Register data while selected, otherwise the next DMA byte
    assign rdata  = cpu_rd ? regs[addr] : src_mem[src_head];
    assign dreq_n = dmadir ? (src_head == src_tail) : ~sink_en;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
            addr        <= '0;
            src_head    <= '0;
            src_tail    <= '0;
            sink_cnt    <= '0;
            wr_count    <= '0;
            prev_rd     <= 1'b0;
            prev_wr     <= 1'b0;
            prev_dma_rd <= 1'b0;
            prev_dma_wr <= 1'b0;
        end else begin
            prev_rd     <= cpu_rd;
            prev_wr     <= cpu_wr;
            prev_dma_rd <= dma_rd;
            prev_dma_wr <= dma_wr;
            if (cpu_wr && !prev_wr) begin
                wr_count <= wr_count + 8'd1;
                if (bus.sel) begin
                    regs[addr] <= bus.wdata;
                    addr       <= addr + 4'd1;     // Data access steps the address
                end else begin
                    addr <= bus.wdata[3:0];
                end
            end
            if (prev_rd && !cpu_rd && bus.sel)
                addr <= addr + 4'd1;
            // Byte is taken by the FIFO on the clock that ends the strobe
            if (prev_dma_rd && !dma_rd)
                src_head <= src_head + 6'd1;
            if (dma_wr && !prev_dma_wr) begin
                sink_mem[sink_cnt] <= bus.wdata;
                sink_cnt           <= sink_cnt + 6'd1;
            end
            if (src_push) begin
                src_mem[src_tail] <= src_byte;
                src_tail          <= src_tail + 6'd1;
            end
        end
    end

endmodule

// ==== hdl/scsi_dma_top.sv ====
// Host side of the FIFO is plain push and pop strobes, with no bus mastering, counters or interrupts
module scsi_dma_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  scsi_bus_pkg::cpu_cycle_t cpu,
    input  logic                     dreq_n,
    input  logic                     dmadir,
    input  logic                     host_push,
    input  logic                     host_pop,
    input  scsi_bus_pkg::scsi_byte_t scsi_rdata,
    input  dma_fifo_pkg::fifo_word_t host_wdata,
    output scsi_bus_pkg::scsi_bus_t  scsi_bus,
    output logic                     dsack,
    output scsi_bus_pkg::scsi_byte_t cpu_rdata,
    output dma_fifo_pkg::fifo_word_t host_rdata,
    output logic                     fifo_empty,
    output logic                     fifo_full
);
    import scsi_bus_pkg::*;
    import dma_fifo_pkg::*;

    scsi_bus_t  bus_ctl;
    fifo_ctl_t  fifo_ctl;
    fifo_stat_t fifo_stat;
    scsi_byte_t fifo_wbyte;
    logic       cpu_req;
    logic       cpu_rw;
    logic       cdsack_n;
    logic       set_dsack;
    logic       cpu2s;
    logic       s2cpu;
    logic       f2s;

    scsi_bus_sequencer seq_i (
        .CLK       (CLK),
        .nRESET    (nRESET),
        .cpu_req   (cpu_req),
        .cpu_rw    (cpu_rw),
        .cdsack_n  (cdsack_n),
        .dreq_n    (dreq_n),
        .dmadir    (dmadir),
        .fifo_stat (fifo_stat),
        .bus_ctl   (bus_ctl),
        .fifo_ctl  (fifo_ctl),
        .set_dsack (set_dsack),
        .cpu2s     (cpu2s),
        .s2cpu     (s2cpu),
        .f2s       (f2s),
        .s2f       ()           // Direction flag not needed at this level
    );

    dma_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .fifo_ctl   (fifo_ctl),
        .scsi_rdata (scsi_rdata),
        .host_push  (host_push),
        .host_pop   (host_pop),
        .host_wdata (host_wdata),
        .fifo_stat  (fifo_stat),
        .scsi_wbyte (fifo_wbyte),
        .host_rdata (host_rdata),
        .empty      (fifo_empty),
        .full       (fifo_full)
    );

    cpu_scsi_port port_i (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .cpu        (cpu),
        .set_dsack  (set_dsack),
        .scsi_rdata (scsi_rdata),
        .cpu_req    (cpu_req),
        .cpu_rw     (cpu_rw),
        .cdsack_n   (cdsack_n),
        .dsack      (dsack),
        .rdata      (cpu_rdata)
    );

    always_comb begin
        scsi_bus     = bus_ctl;
        scsi_bus.sel = (cpu2s | s2cpu) ? cpu.sel : '0;    // Select only matters in CPU cycles
        if (f2s)
            scsi_bus.wdata = fifo_wbyte;
        else if (cpu2s)
            scsi_bus.wdata = cpu.wdata;
        else
            scsi_bus.wdata = '0;
    end

endmodule

// ==== hdl/cpu_scsi_port.sv ====
// Assumes the CPU holds req with stable fields until dsack and then drops it
module cpu_scsi_port (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  scsi_bus_pkg::cpu_cycle_t cpu,
    input  logic                     set_dsack,
    input  scsi_bus_pkg::scsi_byte_t scsi_rdata,
    output logic                     cpu_req,
    output logic                     cpu_rw,
    output logic                     cdsack_n,
    output logic                     dsack,
    output scsi_bus_pkg::scsi_byte_t rdata
);

    // Termination flag, held until the CPU lets go of req
    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            dsack <= 1'b0;
        end else begin
            if (set_dsack)
                dsack <= 1'b1;
            else if (!cpu.req)
                dsack <= 1'b0;
        end
    end

    // IC drives the byte while re and cs are up
    always_ff @(posedge CLK) begin
        if (set_dsack && cpu.rw)
            rdata <= scsi_rdata;
    end

    // A request still held after termination must not start a new cycle
    assign cpu_req  = cpu.req & ~dsack;
    assign cpu_rw   = cpu.rw;
    assign cdsack_n = ~dsack;

endmodule

// ==== hdl/dma_fifo.sv ====
// FIFO_DEPTH must be a power of two, and host push or pop is dropped when a DMA strobe moves that pointer
module dma_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  dma_fifo_pkg::fifo_ctl_t  fifo_ctl,
    input  scsi_bus_pkg::scsi_byte_t scsi_rdata,
    input  logic                     host_push,
    input  logic                     host_pop,
    input  dma_fifo_pkg::fifo_word_t host_wdata,
    output dma_fifo_pkg::fifo_stat_t fifo_stat,
    output scsi_bus_pkg::scsi_byte_t scsi_wbyte,
    output dma_fifo_pkg::fifo_word_t host_rdata,
    output logic                     empty,
    output logic                     full
);
    import dma_fifo_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [AW:0] fifo_ptr_t;        // Top bit tells full from empty

    fifo_word_t mem [2**AW];
    fifo_word_t in_word;                    // Longword under assembly from the IC
    fifo_word_t in_merged;
    fifo_word_t head;
    fifo_ptr_t  ni;
    fifo_ptr_t  no;
    fifo_ptr_t  used;
    byte_ptr_t  bo;
    logic       rififo_d;
    logic       rdfifo_d;
    logic       host_wr;
    logic       host_rd;

    assign used  = ni - no;
    assign empty = (used == '0);
    assign full  = (used == fifo_ptr_t'(FIFO_DEPTH));

    assign host_wr = host_push & ~full & ~fifo_ctl.incni;
    assign host_rd = host_pop & ~empty & ~fifo_ctl.incno;

    // Lane bo sits at bits 8*(3-bo), byte 0 on top
    assign head       = mem[no[AW-1:0]];
    assign host_rdata = head;
    assign scsi_wbyte = head[{~bo, 3'b000} +: 8];

    always_comb begin
        in_merged = in_word;
        in_merged[{~bo, 3'b000} +: 8] = scsi_rdata;
    end

    always_ff @(posedge CLK) begin
        if (fifo_ctl.incbo)
            in_word <= in_merged;
        if (fifo_ctl.rififo)
            mem[ni[AW-1:0]] <= in_merged;   // Last byte goes straight in
        else if (host_wr)
            mem[ni[AW-1:0]] <= host_wdata;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            ni       <= '0;
            no       <= '0;
            bo       <= '0;
            rififo_d <= 1'b0;
            rdfifo_d <= 1'b0;
        end else begin
            if (fifo_ctl.incni || host_wr)
                ni <= ni + 1'b1;
            if (fifo_ctl.incno || host_rd)
                no <= no + 1'b1;
            if (fifo_ctl.incbo)
                bo <= bo + 1'b1;            // Wraps back to lane 0
            rififo_d <= fifo_ctl.rififo;
            rdfifo_d <= fifo_ctl.rdfifo;
        end
    end

    assign fifo_stat.empty    = empty;
    assign fifo_stat.full     = full;
    assign fifo_stat.boeq3    = (bo == 2'd3);
    assign fifo_stat.rififo_d = rififo_d;
    assign fifo_stat.rdfifo_d = rdfifo_d;

endmodule

// ==== hdl/scsi_bus_sequencer.sv ====
// CPU register cycles take priority over DMA and every DMA byte runs four clocks
module scsi_bus_sequencer (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     cpu_req,
    input  logic                     cpu_rw,
    input  logic                     cdsack_n,
    input  logic                     dreq_n,
    input  logic                     dmadir,
    input  dma_fifo_pkg::fifo_stat_t fifo_stat,
    output scsi_bus_pkg::scsi_bus_t  bus_ctl,
    output dma_fifo_pkg::fifo_ctl_t  fifo_ctl,
    output logic                     set_dsack,
    output logic                     cpu2s,
    output logic                     s2cpu,
    output logic                     f2s,
    output logic                     s2f
);
    import scsi_bus_pkg::*;

    seq_state_t state;
    logic       start_s2f;
    logic       start_f2s;
    logic       start_dma_wr;

    // A longword moved last clock must be counted before the next start
    assign start_s2f    = ~dreq_n & ~fifo_stat.full & dmadir & ~cpu_req & ~fifo_stat.rififo_d;
    assign start_f2s    = ~dreq_n & ~fifo_stat.empty & ~dmadir & ~cpu_req & ~fifo_stat.rdfifo_d;
    assign start_dma_wr = ~dmadir & ~cpu_req;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= IDLE_DMA_RD;
        end else begin
            case (state)
                IDLE_DMA_RD: begin
                    if (start_s2f)
                        state <= S2F_1;
                    else if (cpu_req)
                        state <= CPUREQ;
                    else if (start_dma_wr)
                        state <= IDLE_DMA_WR;
                end
                IDLE_DMA_WR: begin
                    if (start_f2s)
                        state <= F2S_1;
                    else if (cpu_req)
                        state <= CPUREQ;
                    else
                        state <= IDLE_DMA_RD;
                end
                CPUREQ: state <= cpu_rw ? S2C_1 : C2S_1;
                // CPU write to IC
                C2S_1:  state <= C2S_2;
                C2S_2:  state <= C2S_3;
                C2S_3:  state <= C2S_4;
                C2S_4:  state <= C2S_5;
                C2S_5:  state <= cdsack_n ? IDLE_DMA_RD : C2S_5;   // Wait for CPU to let go
                // CPU read from IC
                S2C_1:  state <= S2C_2;
                S2C_2:  state <= S2C_3;
                S2C_3:  state <= S2C_4;
                S2C_4:  state <= S2C_5;
                S2C_5:  state <= S2C_6;
                S2C_6:  state <= cdsack_n ? IDLE_DMA_RD : S2C_6;
                // DMA byte out to IC
                F2S_1:  state <= F2S_2;
                F2S_2:  state <= F2S_3;
                F2S_3:  state <= F2S_4;
                F2S_4:  state <= IDLE_DMA_WR;
                // DMA byte in from IC
                S2F_1:  state <= S2F_2;
                S2F_2:  state <= S2F_3;
                S2F_3:  state <= S2F_4;
                S2F_4:  state <= IDLE_DMA_RD;
                default: state <= IDLE_DMA_RD;
            endcase
        end
    end

    // Per-state output decode
    always_comb begin
        bus_ctl   = '0;     // sel and wdata are filled in at the top
        fifo_ctl  = '0;
        set_dsack = 1'b0;
        cpu2s     = 1'b0;
        s2cpu     = 1'b0;
        f2s       = 1'b0;
        s2f       = 1'b0;

        case (state)
            IDLE_DMA_RD: bus_ctl.dack = start_s2f;
            IDLE_DMA_WR: bus_ctl.dack = start_f2s;
            CPUREQ: begin
                bus_ctl.cs = 1'b1;
                bus_ctl.re = cpu_rw;
                bus_ctl.we = ~cpu_rw;
                s2cpu      = cpu_rw;
                cpu2s      = ~cpu_rw;
            end
            C2S_1, C2S_2: begin
                bus_ctl.cs = 1'b1;
                bus_ctl.we = 1'b1;
                cpu2s      = 1'b1;
            end
            C2S_3: begin
                bus_ctl.cs = 1'b1;     // we released, data held one more clock
                cpu2s      = 1'b1;
                set_dsack  = 1'b1;
            end
            F2S_1, F2S_2, F2S_3: begin
                bus_ctl.we   = 1'b1;
                bus_ctl.dack = 1'b1;
                f2s          = 1'b1;
            end
            F2S_4: begin
                fifo_ctl.incbo  = 1'b1;
                fifo_ctl.incno  = fifo_stat.boeq3;   // Head longword fully sent
                fifo_ctl.rdfifo = fifo_stat.boeq3;
            end
            S2C_1, S2C_2: begin
                bus_ctl.cs = 1'b1;
                bus_ctl.re = 1'b1;
                s2cpu      = 1'b1;
            end
            S2C_3: begin
                bus_ctl.cs = 1'b1;
                bus_ctl.re = 1'b1;
                s2cpu      = 1'b1;
                set_dsack  = 1'b1;     // Read byte latched here
            end
            S2C_4: begin
                bus_ctl.re = 1'b1;
                s2cpu      = 1'b1;
            end
            S2C_5, S2C_6: s2cpu = 1'b1;
            S2F_1: begin
                if (fifo_stat.full) begin
                    fifo_ctl.incni = 1'b1;
                    fifo_ctl.incno = 1'b1;
                end else begin
                    bus_ctl.re   = 1'b1;
                    bus_ctl.dack = 1'b1;
                    s2f          = 1'b1;
                end
            end
            S2F_2, S2F_3: begin
                bus_ctl.re   = 1'b1;
                bus_ctl.dack = 1'b1;
                s2f          = 1'b1;
            end
            S2F_4: begin
                s2f             = 1'b1;
                fifo_ctl.incbo  = 1'b1;
                fifo_ctl.incni  = fifo_stat.boeq3;  // Assembled longword stored
                fifo_ctl.rififo = fifo_stat.boeq3;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/dma_fifo_pkg.sv ====
// FIFO types assume big-endian longwords with transfer byte 0 in bits 31 to 24
package dma_fifo_pkg;

    typedef logic [31:0] fifo_word_t;
    typedef logic [1:0]  byte_ptr_t;       // Lane within a longword

    // Strobes from the sequencer
    typedef struct packed {
        logic incbo;        // Advance byte pointer
        logic incni;        // Advance next-in pointer
        logic incno;        // Advance next-out pointer
        logic rdfifo;       // Longword leaves toward the IC
        logic rififo;       // Longword written from the IC
    } fifo_ctl_t;

    // Status back to the sequencer
    typedef struct packed {
        logic empty;
        logic full;
        logic boeq3;        // Byte pointer on last lane
        logic rififo_d;     // rififo one clock late
        logic rdfifo_d;     // rdfifo one clock late
    } fifo_stat_t;

endpackage

// ==== hdl/scsi_bus_pkg.sv ====
// Byte bus and CPU cycle types for a SCSI IC reached indirectly through one select line
package scsi_bus_pkg;

    typedef logic [7:0] scsi_byte_t;
    typedef logic       scsi_reg_sel_t;     // 0 address register, 1 data register

    // IC controls, strobes driven by the sequencer
    typedef struct packed {
        logic          cs;
        logic          re;
        logic          we;
        logic          dack;
        scsi_reg_sel_t sel;
        scsi_byte_t    wdata;
    } scsi_bus_t;

    typedef struct packed {
        logic          req;     // Held until dsack is seen
        logic          rw;      // 1 for read
        scsi_reg_sel_t sel;
        scsi_byte_t    wdata;
    } cpu_cycle_t;

    // Sequencer states with their board encodings
    typedef enum logic [4:0] {
        IDLE_DMA_RD = 5'd0,  CPUREQ = 5'd8,  IDLE_DMA_WR = 5'd16,
        C2S_1 = 5'd17, C2S_2 = 5'd26, C2S_3 = 5'd6,  C2S_4 = 5'd22, C2S_5 = 5'd14,
        F2S_1 = 5'd28, F2S_2 = 5'd2,  F2S_3 = 5'd18, F2S_4 = 5'd1,
        S2C_1 = 5'd10, S2C_2 = 5'd30, S2C_3 = 5'd3,  S2C_4 = 5'd19, S2C_5 = 5'd9,
        S2C_6 = 5'd25,
        S2F_1 = 5'd24, S2F_2 = 5'd4,  S2F_3 = 5'd20, S2F_4 = 5'd12
    } seq_state_t;

endpackage
